/* tb.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/local_mem.sv
rtl/cmd_regs.sv
rtl/master_engine.sv
rtl/target_engine.sv
rtl/bus_device.sv
test/bus_assertions.sv
test/tb_bus_device.sv

/* test/tb_bus_device.sv */
`include "bus_macros.svh"

module tb_bus_device;

  localparam bus_pkg::word_t DEV_ID   = 32'h0000_a000;
  localparam bus_pkg::word_t OTHER_ID = 32'h0000_b000;
  localparam int BURSTS = 7;

  logic                  iframe = 1'b0;
  logic                  reset;
  logic                  cmd_req;
  bus_pkg::word_t        cmd_addr;
  bus_pkg::burst_count_t cmd_count;
  logic                  cmd_ack;
  logic                  cmd_abort;
  logic                  host_we;
  bus_pkg::mem_index_t   host_addr;
  bus_pkg::word_t        host_wdata;
  bus_pkg::word_t        host_rdata;
  logic                  gnt_n;
  logic                  req_n;
  bus_pkg::word_t        ad_out;
  logic                  ad_oe;
  logic                  cbe_out;
  logic                  frame_n_out;
  logic                  frame_oe;
  logic                  irdy_n_out;
  logic                  trdy_n_out;
  logic                  devsel_n_out;
  logic                  target_oe;
  // testbench side of the shared lines
  bus_pkg::word_t        ad_drv;
  logic                  cbe_drv;
  logic                  frame_drv;
  logic                  irdy_drv;
  logic                  trdy_drv;
  logic                  devsel_drv;
  // resolved bus as seen by every agent
  bus_pkg::word_t        ad_in;
  logic                  cbe_in;
  logic                  frame_n_in;
  logic                  irdy_n_in;
  logic                  trdy_n_in;
  logic                  devsel_n_in;
  int                    lengths [BURSTS];
  int                    limit;
  int                    cycles = 0;

  assign ad_in       = ad_oe ? ad_out : ad_drv;
  assign cbe_in      = frame_oe ? cbe_out : cbe_drv;
  assign frame_n_in  = frame_oe ? frame_n_out : frame_drv;
  assign irdy_n_in   = frame_oe ? irdy_n_out : irdy_drv;
  assign trdy_n_in   = target_oe ? trdy_n_out : trdy_drv;
  assign devsel_n_in = target_oe ? devsel_n_out : devsel_drv;

  bus_device uut (
    .dev_id (DEV_ID),
    .*
  );

  always #4 iframe = ~iframe;

  always @(posedge iframe)
  begin
    cycles++;
    if (uut.u_chk.failed)
    begin
      $display("Test failed");
      $fatal(1, "bus checker reported an assertion failure");
    end
    else if (cycles >= limit)
    begin
      $display("Test failed");
      $fatal(1, "timeout, stimulus still running after %0d cycles", limit);
    end
  end

  task automatic host_fill();
    for (int i = 0; i < `MEM_WORDS; i++)
    begin
      @(posedge iframe);
      host_we    <= 1'b1;
      host_addr  <= bus_pkg::mem_index_t'(i);
      host_wdata <= $urandom;
    end
    @(posedge iframe);
    host_we <= 1'b0;
  endtask

  // walk the host read port over the whole memory
  task automatic host_sweep();
    for (int i = 0; i < `MEM_WORDS; i++)
    begin
      @(posedge iframe);
      host_addr <= bus_pkg::mem_index_t'(i);
    end
  endtask

  task automatic initiator_burst(input logic rd, input int n);
    @(posedge iframe);
    frame_drv <= 1'b0;
    cbe_drv   <= rd;
    ad_drv    <= DEV_ID;
    @(posedge iframe);
    for (int k = 0; k < n; k++)
    begin
      if ($urandom_range(3) == 0)
      begin
        irdy_drv <= 1'b1;
        @(posedge iframe);
      end
      irdy_drv  <= 1'b0;
      frame_drv <= (k == n - 1);
      ad_drv    <= rd ? '0 : $urandom;
      do
        @(posedge iframe);
      while (irdy_n_in || trdy_n_in);
    end
    irdy_drv <= 1'b1;
    ad_drv   <= '0;
    repeat (2) @(posedge iframe);
  endtask

  // arbiter and target for one host command
  task automatic master_burst(input bus_pkg::word_t addr, input int n, input logic respond);
    logic last;
    @(posedge iframe);
    cmd_addr  <= addr;
    cmd_count <= bus_pkg::burst_count_t'(n);
    cmd_req   <= 1'b1;
    do
      @(posedge iframe);
    while (req_n);
    gnt_n <= 1'b0;
    do
      @(posedge iframe);
    while (!(frame_oe && !frame_n_out));
    gnt_n <= 1'b1;
    if (respond)
    begin
      devsel_drv <= 1'b0;
      trdy_drv   <= ($urandom_range(3) == 0);
      do
      begin
        @(posedge iframe);
        last = !irdy_n_in && !trdy_n_in && frame_n_in;
        trdy_drv <= last || ($urandom_range(3) == 0);
      end
      while (!last);
      devsel_drv <= 1'b1;
    end
    do
      @(posedge iframe);
    while (!cmd_ack);
    cmd_req <= 1'b0;
    do
      @(posedge iframe);
    while (cmd_ack);
  endtask

  initial
  begin
    int total;
    void'($urandom(32'h5bbea84c));
    reset      <= 1'b1;
    cmd_req    <= 1'b0;
    cmd_addr   <= '0;
    cmd_count  <= '0;
    host_we    <= 1'b0;
    host_addr  <= '0;
    host_wdata <= '0;
    gnt_n      <= 1'b1;
    ad_drv     <= '0;
    cbe_drv    <= 1'b0;
    frame_drv  <= 1'b1;
    irdy_drv   <= 1'b1;
    trdy_drv   <= 1'b1;
    devsel_drv <= 1'b1;
    total = 0;
    for (int b = 0; b < BURSTS; b++)
    begin
      lengths[b] = $urandom_range(`MEM_WORDS, 1);
      total += lengths[b];
    end
    limit = 4 * total + 200;
    repeat (10) @(posedge iframe);
    reset <= 1'b0;
    host_fill();
    initiator_burst(1'b0, lengths[0]);
    host_sweep();
    initiator_burst(1'b1, lengths[1]);
    initiator_burst(1'b0, lengths[2]);
    host_sweep();
    initiator_burst(1'b1, lengths[3]);
    master_burst(OTHER_ID, lengths[4], 1'b1);
    // nobody answers this one, so the master must abort
    master_burst(OTHER_ID + 32'h10, lengths[5], 1'b0);
    master_burst(OTHER_ID, lengths[6], 1'b1);
    repeat (4) @(posedge iframe);
    if (uut.u_chk.failed)
    begin
      $display("Test failed");
      $fatal(1, "bus checker reported an assertion failure");
    end
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* test/bus_assertions.sv */
`include "bus_macros.svh"

module bus_checker (
  input logic                  iframe,
  input logic                  reset,
  input bus_pkg::word_t        dev_id,
  input logic                  cmd_req,
  input bus_pkg::word_t        cmd_addr,
  input bus_pkg::burst_count_t cmd_count,
  input logic                  cmd_ack,
  input logic                  cmd_abort,
  input logic                  done,
  input logic                  host_we,
  input bus_pkg::mem_index_t   host_addr,
  input bus_pkg::word_t        host_wdata,
  input bus_pkg::word_t        host_rdata,
  input bus_pkg::word_t        ad_in,
  input bus_pkg::word_t        ad_out,
  input logic                  ad_oe,
  input logic                  cbe_in,
  input logic                  cbe_out,
  input logic                  frame_n_in,
  input logic                  frame_n_out,
  input logic                  frame_oe,
  input logic                  irdy_n_in,
  input logic                  irdy_n_out,
  input logic                  trdy_n_in,
  input logic                  trdy_n_out,
  input logic                  devsel_n_in,
  input logic                  devsel_n_out,
  input logic                  target_oe,
  input logic                  req_n
);

  bus_pkg::word_t        shadow [`MEM_WORDS];
  logic                  failed = 1'b0;
  logic                  frame_q;
  logic                  tgt_wr;
  logic                  tgt_rd;
  bus_pkg::mem_index_t   tgt_idx;
  bus_pkg::mem_index_t   mst_idx;
  bus_pkg::burst_count_t mst_count;
  logic                  mst_claimed;
  logic                  claim;
  logic                  tgt_xfer;
  logic                  mst_addr_phase;
  logic                  mst_data;
  logic                  mst_xfer;
  logic [9:0]            reset_view;
  bus_pkg::word_t        host_expect;
  bus_pkg::word_t        tgt_expect;
  bus_pkg::word_t        mst_expect;

  function automatic bus_pkg::mem_index_t wrap_next(input bus_pkg::mem_index_t idx);
    if (int'(idx) == `MEM_WORDS - 1)
      return '0;
    return idx + 1'b1;
  endfunction

  assign claim          = frame_q && !frame_n_in && (ad_in == dev_id);
  assign tgt_xfer       = (tgt_wr || tgt_rd) && !irdy_n_in && !trdy_n_out;
  // address cycle has frame low while irdy is still high
  assign mst_addr_phase = frame_oe && !frame_n_out && irdy_n_out;
  assign mst_data       = frame_oe && !irdy_n_out;
  assign mst_xfer       = mst_data && !trdy_n_in && !devsel_n_in;
  assign reset_view     = {req_n, frame_n_out, irdy_n_out, trdy_n_out, devsel_n_out,
                           frame_oe, ad_oe, target_oe, cmd_ack, cmd_abort};
  assign host_expect    = shadow[host_addr];
  assign tgt_expect     = shadow[tgt_idx];
  assign mst_expect     = shadow[mst_idx];

  always_ff @(posedge iframe)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MEM_WORDS; i++)
        shadow[i] <= '0;
      frame_q     <= 1'b1;
      tgt_wr      <= 1'b0;
      tgt_rd      <= 1'b0;
      tgt_idx     <= '0;
      mst_idx     <= '0;
      mst_count   <= '0;
      mst_claimed <= 1'b0;
    end
    else
    begin
      frame_q <= frame_n_in;
      if (host_we && int'(host_addr) < `MEM_WORDS)
        shadow[host_addr] <= host_wdata;
      if (claim)
      begin
        tgt_wr  <= !cbe_in;
        tgt_rd  <= cbe_in;
        tgt_idx <= '0;
      end
      else if (tgt_xfer)
      begin
        if (tgt_wr)
          shadow[tgt_idx] <= ad_in;
        tgt_idx <= wrap_next(tgt_idx);
        // transfer with frame high closes the burst
        if (frame_n_in)
        begin
          tgt_wr <= 1'b0;
          tgt_rd <= 1'b0;
        end
      end
      if (mst_addr_phase)
      begin
        mst_idx     <= '0;
        mst_count   <= cmd_count;
        mst_claimed <= 1'b0;
      end
      else if (mst_data)
      begin
        if (!devsel_n_in)
          mst_claimed <= 1'b1;
        if (mst_xfer)
          mst_idx <= wrap_next(mst_idx);
      end
    end
  end

  a_reset_state: assert property (@(posedge iframe) reset |=> reset_view == 10'h3e0)
  else
  begin
    $error("** Error: reset_view expected %h got %h", 10'h3e0, $sampled(reset_view));
    failed = 1'b1;
  end

  a_host_rdata: assert property (@(posedge iframe) disable iff (reset)
    int'(host_addr) < `MEM_WORDS |-> host_rdata == host_expect)
  else
  begin
    $error("** Error: host_rdata expected %h got %h", $sampled(host_expect),
           $sampled(host_rdata));
    failed = 1'b1;
  end

  a_read_data: assert property (@(posedge iframe) disable iff (reset)
    tgt_rd && tgt_xfer |-> ad_oe && ad_out == tgt_expect)
  else
  begin
    $error("** Error: ad_out expected %h got %h", $sampled(tgt_expect), $sampled(ad_out));
    failed = 1'b1;
  end

  a_turnaround: assert property (@(posedge iframe) disable iff (reset)
    tgt_rd && $fell(devsel_n_out) |-> trdy_n_out)
  else
  begin
    $error("** Error: trdy_n_out expected %h got %h", 1'b1, $sampled(trdy_n_out));
    failed = 1'b1;
  end

  a_master_addr: assert property (@(posedge iframe) disable iff (reset)
    mst_addr_phase |-> ad_oe && ad_out == cmd_addr)
  else
  begin
    $error("** Error: ad_out expected %h got %h", $sampled(cmd_addr), $sampled(ad_out));
    failed = 1'b1;
  end

  // master only issues writes
  a_master_cmd: assert property (@(posedge iframe) disable iff (reset)
    mst_addr_phase |-> !cbe_out)
  else
  begin
    $error("** Error: cbe_out expected %h got %h", 1'b0, $sampled(cbe_out));
    failed = 1'b1;
  end

  a_master_data: assert property (@(posedge iframe) disable iff (reset)
    mst_xfer |-> ad_oe && ad_out == mst_expect)
  else
  begin
    $error("** Error: ad_out expected %h got %h", $sampled(mst_expect), $sampled(ad_out));
    failed = 1'b1;
  end

  a_master_frame: assert property (@(posedge iframe) disable iff (reset)
    mst_data |-> frame_n_out == (mst_idx == mst_count - 1'b1))
  else
  begin
    $error("** Error: frame_n_out expected %h got %h", $sampled(mst_idx == mst_count - 1'b1),
           $sampled(frame_n_out));
    failed = 1'b1;
  end

  a_no_claim: assert property (@(posedge iframe) disable iff (reset)
    frame_q && !frame_n_in && ad_in != dev_id |=> devsel_n_out)
  else
  begin
    $error("** Error: devsel_n_out expected %h got %h", 1'b1, $sampled(devsel_n_out));
    failed = 1'b1;
  end

  a_ack_rise: assert property (@(posedge iframe) disable iff (reset)
    $rose(cmd_ack) |-> $past(done))
  else
  begin
    $error("** Error: done expected %h got %h before cmd_ack", 1'b1, 1'b0);
    failed = 1'b1;
  end

  a_ack_fall: assert property (@(posedge iframe) disable iff (reset)
    cmd_ack && !cmd_req |=> !cmd_ack)
  else
  begin
    $error("** Error: cmd_ack expected %h got %h", 1'b0, $sampled(cmd_ack));
    failed = 1'b1;
  end

  a_abort: assert property (@(posedge iframe) disable iff (reset)
    $rose(cmd_ack) |-> cmd_abort == !mst_claimed)
  else
  begin
    $error("** Error: cmd_abort expected %h got %h", $sampled(!mst_claimed),
           $sampled(cmd_abort));
    failed = 1'b1;
  end

endmodule

bind bus_device bus_checker u_chk (.*);

/* rtl/bus_device.sv */
module bus_device (
  input  logic                  iframe,
  input  logic                  reset,
  input  bus_pkg::word_t        dev_id,
  input  logic                  cmd_req,
  input  bus_pkg::word_t        cmd_addr,
  input  bus_pkg::burst_count_t cmd_count,
  output logic                  cmd_ack,
  output logic                  cmd_abort,
  input  logic                  host_we,
  input  bus_pkg::mem_index_t   host_addr,
  input  bus_pkg::word_t        host_wdata,
  output bus_pkg::word_t        host_rdata,
  input  bus_pkg::word_t        ad_in,
  output bus_pkg::word_t        ad_out,
  output logic                  ad_oe,
  input  logic                  cbe_in,
  output logic                  cbe_out,
  input  logic                  frame_n_in,
  output logic                  frame_n_out,
  output logic                  frame_oe,
  input  logic                  irdy_n_in,
  output logic                  irdy_n_out,
  input  logic                  trdy_n_in,
  output logic                  trdy_n_out,
  input  logic                  devsel_n_in,
  output logic                  devsel_n_out,
  output logic                  target_oe,
  output logic                  req_n,
  input  logic                  gnt_n
);

  bus_pkg::word_t        burst_addr;
  bus_pkg::burst_count_t burst_count;
  logic                  start;
  logic                  done;
  logic                  abort;
  bus_pkg::mem_index_t   master_raddr;
  bus_pkg::word_t        master_rdata;
  bus_pkg::mem_index_t   target_raddr;
  bus_pkg::word_t        target_rdata;
  logic                  bus_we;
  bus_pkg::mem_index_t   bus_waddr;
  bus_pkg::word_t        bus_wdata;
  bus_pkg::word_t        master_ad_out;
  logic                  master_ad_oe;
  bus_pkg::word_t        target_ad_out;
  logic                  target_ad_oe;

  // only one engine drives the lines at a time
  assign ad_oe  = master_ad_oe | target_ad_oe;
  assign ad_out = master_ad_oe ? master_ad_out : target_ad_out;

  local_mem u_mem (
    .iframe       (iframe),
    .reset        (reset),
    .host_we      (host_we),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .bus_we       (bus_we),
    .bus_waddr    (bus_waddr),
    .bus_wdata    (bus_wdata),
    .master_raddr (master_raddr),
    .target_raddr (target_raddr),
    .host_rdata   (host_rdata),
    .master_rdata (master_rdata),
    .target_rdata (target_rdata)
  );

  cmd_regs u_cmd (
    .iframe      (iframe),
    .reset       (reset),
    .cmd_req     (cmd_req),
    .cmd_addr    (cmd_addr),
    .cmd_count   (cmd_count),
    .done        (done),
    .abort       (abort),
    .cmd_ack     (cmd_ack),
    .cmd_abort   (cmd_abort),
    .start       (start),
    .burst_addr  (burst_addr),
    .burst_count (burst_count)
  );

  master_engine u_master (
    .iframe      (iframe),
    .reset       (reset),
    .start       (start),
    .burst_addr  (burst_addr),
    .burst_count (burst_count),
    .gnt_n       (gnt_n),
    .frame_n_in  (frame_n_in),
    .irdy_n_in   (irdy_n_in),
    .trdy_n_in   (trdy_n_in),
    .devsel_n_in (devsel_n_in),
    .mem_rdata   (master_rdata),
    .req_n       (req_n),
    .frame_n_out (frame_n_out),
    .irdy_n_out  (irdy_n_out),
    .cbe_out     (cbe_out),
    .frame_oe    (frame_oe),
    .ad_out      (master_ad_out),
    .ad_oe       (master_ad_oe),
    .mem_raddr   (master_raddr),
    .done        (done),
    .abort       (abort)
  );

  target_engine u_target (
    .iframe       (iframe),
    .reset        (reset),
    .dev_id       (dev_id),
    .frame_n_in   (frame_n_in),
    .irdy_n_in    (irdy_n_in),
    .cbe_in       (cbe_in),
    .ad_in        (ad_in),
    .mem_rdata    (target_rdata),
    .trdy_n_out   (trdy_n_out),
    .devsel_n_out (devsel_n_out),
    .target_oe    (target_oe),
    .ad_out       (target_ad_out),
    .ad_oe        (target_ad_oe),
    .mem_we       (bus_we),
    .mem_waddr    (bus_waddr),
    .mem_wdata    (bus_wdata),
    .mem_raddr    (target_raddr)
  );

endmodule

/* rtl/target_engine.sv */
`include "bus_macros.svh"

module target_engine (
  input  logic                iframe,
  input  logic                reset,
  input  bus_pkg::word_t      dev_id,
  input  logic                frame_n_in,
  input  logic                irdy_n_in,
  input  logic                cbe_in,
  input  bus_pkg::word_t      ad_in,
  input  bus_pkg::word_t      mem_rdata,
  output logic                trdy_n_out,
  output logic                devsel_n_out,
  output logic                target_oe,
  output bus_pkg::word_t      ad_out,
  output logic                ad_oe,
  output logic                mem_we,
  output bus_pkg::mem_index_t mem_waddr,
  output bus_pkg::word_t      mem_wdata,
  output bus_pkg::mem_index_t mem_raddr
);

  localparam bus_pkg::mem_index_t LAST_INDEX = bus_pkg::mem_index_t'(`MEM_WORDS - 1);

  bus_pkg::target_state_t state;
  bus_pkg::mem_index_t    idx;
  bus_pkg::mem_index_t    next_idx;
  logic                   frame_q;
  logic                   claim;
  logic                   transfer;

  // address phase is the cycle frame falls
  assign claim    = frame_q && !frame_n_in && (ad_in == dev_id);
  assign transfer = !irdy_n_in && !trdy_n_out;
  assign next_idx = (idx == LAST_INDEX) ? '0 : idx + 1'b1;

  assign mem_we    = (state == bus_pkg::t_write_data) && transfer;
  assign mem_waddr = idx;
  assign mem_wdata = ad_in;
  // during read data the word after the current one is fetched ahead
  assign mem_raddr = (state == bus_pkg::t_read_data) ? next_idx : idx;

  always_ff @(posedge iframe)
  begin
    if (reset)
      frame_q <= 1'b1;
    else
      frame_q <= frame_n_in;
  end

  always_ff @(posedge iframe)
  begin
    if (reset)
    begin
      state        <= bus_pkg::t_idle;
      trdy_n_out   <= 1'b1;
      devsel_n_out <= 1'b1;
      target_oe    <= 1'b0;
      ad_oe        <= 1'b0;
      idx          <= '0;
    end
    else
    begin
      case (state)
        bus_pkg::t_idle:
        begin
          if (claim)
          begin
            idx          <= '0;
            devsel_n_out <= 1'b0;
            target_oe    <= 1'b1;
            if (cbe_in)
              state <= bus_pkg::t_turnaround;
            else
            begin
              trdy_n_out <= 1'b0;
              state      <= bus_pkg::t_write_data;
            end
          end
        end
        bus_pkg::t_write_data:
        begin
          if (transfer)
          begin
            idx <= next_idx;
            if (frame_n_in)
            begin
              trdy_n_out   <= 1'b1;
              devsel_n_out <= 1'b1;
              state        <= bus_pkg::t_release;
            end
          end
        end
        bus_pkg::t_turnaround:
        begin
          trdy_n_out <= 1'b0;
          ad_oe      <= 1'b1;
          ad_out     <= mem_rdata;
          state      <= bus_pkg::t_read_data;
        end
        bus_pkg::t_read_data:
        begin
          if (transfer)
          begin
            if (frame_n_in)
            begin
              trdy_n_out   <= 1'b1;
              devsel_n_out <= 1'b1;
              ad_oe        <= 1'b0;
              state        <= bus_pkg::t_release;
            end
            else
            begin
              ad_out <= mem_rdata;
              idx    <= next_idx;
            end
          end
        end
        bus_pkg::t_release:
        begin
          // controls were driven high last cycle, now let go of them
          target_oe <= 1'b0;
          state     <= bus_pkg::t_idle;
        end
        default:
          state <= bus_pkg::t_idle;
      endcase
    end
  end

endmodule

/* rtl/master_engine.sv */
`include "bus_macros.svh"

module master_engine (
  input  logic                  iframe,
  input  logic                  reset,
  input  logic                  start,
  input  bus_pkg::word_t        burst_addr,
  input  bus_pkg::burst_count_t burst_count,
  input  logic                  gnt_n,
  input  logic                  frame_n_in,
  input  logic                  irdy_n_in,
  input  logic                  trdy_n_in,
  input  logic                  devsel_n_in,
  input  bus_pkg::word_t        mem_rdata,
  output logic                  req_n,
  output logic                  frame_n_out,
  output logic                  irdy_n_out,
  output logic                  cbe_out,
  output logic                  frame_oe,
  output bus_pkg::word_t        ad_out,
  output logic                  ad_oe,
  output bus_pkg::mem_index_t   mem_raddr,
  output logic                  done,
  output logic                  abort
);

  localparam int WAIT_WIDTH = $clog2(`DEVSEL_TIMEOUT) + 1;
  localparam logic [WAIT_WIDTH-1:0] WAIT_LAST = WAIT_WIDTH'(`DEVSEL_TIMEOUT - 1);
  localparam bus_pkg::mem_index_t LAST_INDEX = bus_pkg::mem_index_t'(`MEM_WORDS - 1);

  bus_pkg::master_state_t state;
  // index of the next word to fetch from memory
  bus_pkg::mem_index_t    idx;
  bus_pkg::mem_index_t    next_idx;
  logic [WAIT_WIDTH-1:0]  wait_cnt;
  logic                   transfer;
  logic                   bus_idle;

  assign next_idx  = (idx == LAST_INDEX) ? '0 : idx + 1'b1;
  assign transfer  = !trdy_n_in && !devsel_n_in;
  assign bus_idle  = frame_n_in && irdy_n_in;
  assign mem_raddr = idx;

  always_ff @(posedge iframe)
  begin
    if (reset)
    begin
      state       <= bus_pkg::m_idle;
      req_n       <= 1'b1;
      frame_n_out <= 1'b1;
      irdy_n_out  <= 1'b1;
      cbe_out     <= 1'b1;
      frame_oe    <= 1'b0;
      ad_oe       <= 1'b0;
      done        <= 1'b0;
      abort       <= 1'b0;
      idx         <= '0;
      wait_cnt    <= '0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        bus_pkg::m_idle:
        begin
          if (start)
          begin
            req_n <= 1'b0;
            abort <= 1'b0;
            state <= bus_pkg::m_request;
          end
        end
        bus_pkg::m_request:
        begin
          if (!gnt_n && bus_idle)
          begin
            req_n       <= 1'b1;
            frame_oe    <= 1'b1;
            ad_oe       <= 1'b1;
            frame_n_out <= 1'b0;
            cbe_out     <= 1'b0;
            ad_out      <= burst_addr;
            idx         <= '0;
            wait_cnt    <= '0;
            state       <= bus_pkg::m_address;
          end
        end
        bus_pkg::m_address:
        begin
          // first word goes out, frame rises at once for a single-word burst
          irdy_n_out  <= 1'b0;
          ad_out      <= mem_rdata;
          frame_n_out <= (idx == burst_count - 1'b1);
          idx         <= next_idx;
          state       <= bus_pkg::m_data;
        end
        bus_pkg::m_data:
        begin
          if (transfer)
          begin
            if (frame_n_out)
            begin
              irdy_n_out <= 1'b1;
              state      <= bus_pkg::m_release;
            end
            else
            begin
              ad_out      <= mem_rdata;
              frame_n_out <= (idx == burst_count - 1'b1);
              idx         <= next_idx;
            end
          end
          else if (devsel_n_in)
          begin
            // nobody claimed the address, give up
            if (wait_cnt == WAIT_LAST)
            begin
              abort       <= 1'b1;
              frame_n_out <= 1'b1;
              irdy_n_out  <= 1'b1;
              state       <= bus_pkg::m_release;
            end
            else
              wait_cnt <= wait_cnt + 1'b1;
          end
        end
        bus_pkg::m_release:
        begin
          frame_oe    <= 1'b0;
          ad_oe       <= 1'b0;
          frame_n_out <= 1'b1;
          irdy_n_out  <= 1'b1;
          cbe_out     <= 1'b1;
          done        <= 1'b1;
          state       <= bus_pkg::m_idle;
        end
        default:
          state <= bus_pkg::m_idle;
      endcase
    end
  end

endmodule

/* rtl/cmd_regs.sv */
module cmd_regs (
  input  logic                  iframe,
  input  logic                  reset,
  input  logic                  cmd_req,
  input  bus_pkg::word_t        cmd_addr,
  input  bus_pkg::burst_count_t cmd_count,
  input  logic                  done,
  input  logic                  abort,
  output logic                  cmd_ack,
  output logic                  cmd_abort,
  output logic                  start,
  output bus_pkg::word_t        burst_addr,
  output bus_pkg::burst_count_t burst_count
);

  // high from accepting a command until the master reports done
  logic busy;

  always_ff @(posedge iframe)
  begin
    if (reset)
    begin
      busy      <= 1'b0;
      start     <= 1'b0;
      cmd_ack   <= 1'b0;
      cmd_abort <= 1'b0;
    end
    else
    begin
      start <= 1'b0;

      // a request is only taken once the previous ack has dropped
      if (cmd_req && !busy && !cmd_ack)
      begin
        busy  <= 1'b1;
        start <= 1'b1;
      end

      if (done && busy)
      begin
        busy      <= 1'b0;
        cmd_ack   <= 1'b1;
        cmd_abort <= abort;
      end

      if (cmd_ack && !cmd_req)
        cmd_ack <= 1'b0;
    end
  end

  // address and count steering the master for this burst
  always_ff @(posedge iframe)
  begin
    if (cmd_req && !busy && !cmd_ack)
    begin
      burst_addr  <= cmd_addr;
      burst_count <= cmd_count;
    end
  end

endmodule

/* rtl/local_mem.sv */
`include "bus_macros.svh"

module local_mem (
  input  logic               iframe,
  input  logic               reset,
  input  logic               host_we,
  input  bus_pkg::mem_index_t host_addr,
  input  bus_pkg::word_t     host_wdata,
  input  logic               bus_we,
  input  bus_pkg::mem_index_t bus_waddr,
  input  bus_pkg::word_t     bus_wdata,
  input  bus_pkg::mem_index_t master_raddr,
  input  bus_pkg::mem_index_t target_raddr,
  output bus_pkg::word_t     host_rdata,
  output bus_pkg::word_t     master_rdata,
  output bus_pkg::word_t     target_rdata
);

  bus_pkg::word_t mem [`MEM_WORDS];

  // indices past the last word read as zero
  function automatic bus_pkg::word_t read_word(input bus_pkg::mem_index_t addr);
    if (int'(addr) < `MEM_WORDS)
      return mem[addr];
    return '0;
  endfunction

  always_ff @(posedge iframe)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MEM_WORDS; i++)
        mem[i] <= '0;
    end
    else
    begin
      // bus side wins a same-cycle collision
      if (bus_we && int'(bus_waddr) < `MEM_WORDS)
        mem[bus_waddr] <= bus_wdata;
      if (host_we && int'(host_addr) < `MEM_WORDS && !(bus_we && bus_waddr == host_addr))
        mem[host_addr] <= host_wdata;
    end
  end

  always_comb
  begin
    host_rdata   = read_word(host_addr);
    master_rdata = read_word(master_raddr);
    target_rdata = read_word(target_raddr);
  end

endmodule

/* rtl/bus_pkg.sv */
`include "bus_macros.svh"

package bus_pkg;

  // one bus word, either address or data
  typedef logic [`BUS_WIDTH-1:0] word_t;

  typedef logic [`INDEX_WIDTH-1:0] mem_index_t;

  // words per master burst, 1 to MEM_WORDS
  typedef logic [`INDEX_WIDTH-1:0] burst_count_t;

  typedef enum logic [2:0] {
    m_idle,
    m_request,
    m_address,
    m_data,
    m_release
  } master_state_t;

  typedef enum logic [2:0] {
    t_idle,
    t_write_data,
    t_turnaround,
    t_read_data,
    t_release
  } target_state_t;

endpackage

/* rtl/bus_macros.svh */
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// address/data line width
`define BUS_WIDTH 32

// local memory depth in words
`define MEM_WORDS 10

// bits needed to index the memory
`define INDEX_WIDTH 4

// cycles the master waits for a target to claim the bus
`define DEVSEL_TIMEOUT 5

`endif
